// ==== verilog/board_macros.svh ====
/* Board control constants
   Status-word fields, joystick button positions and reset timing */
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// OSD status word bit positions
`define BOARD_ST_FLIP    1
`define BOARD_ST_ROT     2
`define BOARD_ST_TEST    3
`define BOARD_ST_PAUSE   4
`define BOARD_ST_FX_LO   5      // Effect level takes bits 6..5
`define BOARD_ST_FM      7
`define BOARD_ST_PSG     8

// Joystick word buttons, moved up one with three buttons
`define BOARD_COIN_BIT   6
`define BOARD_START_BIT  7
`define BOARD_PAUSE_BIT  8

`define BOARD_RST_LEN    32     // Core reset stretch in cycles
`define BOARD_SYNC_DEPTH 2      // Flops per input synchroniser

`endif

// ==== verilog/board_pkg.sv ====
/* Shared types of the arcade board control block */
package board_pkg;

    // Bits 3..0 are right, left, down, up; buttons above
    typedef logic [9:0]  joy_t;

    // Decoded keyboard levels, MSB first
    //   [30:21] joy1   [20:11] joy2   [10:9] start   [8:7] coin
    //   [6] reset      [5] pause      [4] service    [3:0] gfx
    typedef logic [30:0] key_t;

    typedef logic [1:0]  pair_t;      // Bit 0 is player 1
    typedef logic [3:0]  gfx_t;
    typedef logic [31:0] status_t;
    typedef logic [1:0]  fxlevel_t;

    typedef enum logic {
        RST_IDLE,
        RST_STRETCH
    } rst_state_t;

endpackage

// ==== verilog/pad_sync.sv ====
/* Input synchroniser for joysticks and keys
   Also flags rising edges of pause, reset and graphics-layer keys */
`timescale 1ns/1ps
`include "board_macros.svh"

module pad_sync #(
    parameter int THREE_BUTTONS = 0
) (
    input  logic            clk_sys,
    input  logic            game_rst,
    input  board_pkg::joy_t board_joystick1,
    input  board_pkg::joy_t board_joystick2,
    input  board_pkg::key_t keys,
    output board_pkg::joy_t joy1_s,
    output board_pkg::joy_t joy2_s,
    output board_pkg::key_t keys_s,
    output logic            pause_rise,
    output logic            reset_rise,
    output board_pkg::gfx_t gfx_rise
);

    localparam int PAUSE_BIT = `BOARD_PAUSE_BIT + THREE_BUTTONS;
    localparam int W = 2 * $bits(board_pkg::joy_t) + $bits(board_pkg::key_t);

    logic [`BOARD_SYNC_DEPTH-1:0][W-1:0] sync_q;
    logic            joy_pause;
    logic            last_key_pause, last_joy_pause, last_reset;
    board_pkg::gfx_t last_gfx;

    always_ff @(posedge clk_sys) begin
        sync_q[0] <= {board_joystick1, board_joystick2, keys};
        for (int i = 1; i < `BOARD_SYNC_DEPTH; i++) begin
            sync_q[i] <= sync_q[i-1];
        end
    end

    assign {joy1_s, joy2_s, keys_s} = sync_q[`BOARD_SYNC_DEPTH-1];

    assign joy_pause = joy1_s[PAUSE_BIT] | joy2_s[PAUSE_BIT];

    // Held high in reset so a key already down gives no edge on release
    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            last_key_pause <= 1'b1;
            last_joy_pause <= 1'b1;
            last_reset     <= 1'b1;
            last_gfx       <= '1;
        end else begin
            last_key_pause <= keys_s[5];
            last_joy_pause <= joy_pause;
            last_reset     <= keys_s[6];
            last_gfx       <= keys_s[3:0];
        end
    end

    assign pause_rise = (keys_s[5] & ~last_key_pause) | (joy_pause & ~last_joy_pause);
    assign reset_rise = keys_s[6] & ~last_reset;
    assign gfx_rise   = keys_s[3:0] & ~last_gfx;

endmodule

// ==== verilog/dip_decode.sv ====
/* OSD status word decoder, one register stage per setting */
`timescale 1ns/1ps
`include "board_macros.svh"

module dip_decode (
    input  logic                clk_sys,
    input  logic                game_rst,
    input  board_pkg::status_t  status,
    output logic                rot_control,
    output logic                dip_flip,
    output logic                dip_test,
    output logic                dip_pause,
    output board_pkg::fxlevel_t dip_fxlevel,
    output logic                enable_fm,
    output logic                enable_psg
);

    // Single sampling point for settings used across the block
    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            rot_control <= 1'b0;
            dip_flip    <= 1'b0;
            dip_test    <= 1'b0;
            dip_pause   <= 1'b0;
            dip_fxlevel <= '0;
            enable_fm   <= 1'b0;
            enable_psg  <= 1'b0;
        end else begin
            rot_control <= status[`BOARD_ST_ROT];
            dip_flip    <= status[`BOARD_ST_FLIP];   // A change here restarts the core
            dip_test    <= status[`BOARD_ST_TEST];
            dip_pause   <= status[`BOARD_ST_PAUSE];
            dip_fxlevel <= status[`BOARD_ST_FX_LO +: $bits(board_pkg::fxlevel_t)];
            enable_fm   <= status[`BOARD_ST_FM];
            enable_psg  <= status[`BOARD_ST_PSG];
        end
    end

endmodule

// ==== verilog/input_mapper.sv ====
/* Player input mapper: merge, rotation and polarity of game inputs
   Holds the pause toggle and graphics-layer enables */
`timescale 1ns/1ps
`include "board_macros.svh"

module input_mapper #(
    parameter int THREE_BUTTONS     = 0,
    parameter int INPUTS_ACTIVE_LOW = 1
) (
    input  logic             clk_sys,
    input  logic             game_rst,
    input  board_pkg::joy_t  joy1_s,
    input  board_pkg::joy_t  joy2_s,
    input  board_pkg::key_t  keys_s,
    input  logic             pause_rise,
    input  logic             reset_rise,
    input  board_pkg::gfx_t  gfx_rise,
    input  logic             rot_control,
    input  logic             dip_pause,
    output board_pkg::joy_t  game_joystick1,
    output board_pkg::joy_t  game_joystick2,
    output board_pkg::pair_t game_coin,
    output board_pkg::pair_t game_start,
    output logic             game_service,
    output logic             game_pause,
    output board_pkg::gfx_t  gfx_en,
    output logic             soft_rst
);

    localparam int COIN_BIT  = `BOARD_COIN_BIT + THREE_BUTTONS;
    localparam int START_BIT = `BOARD_START_BIT + THREE_BUTTONS;
    localparam bit INV       = INPUTS_ACTIVE_LOW != 0;

    board_pkg::joy_t  key_joy1, key_joy2;
    board_pkg::pair_t key_start, key_coin;
    logic             pause_tgl;

    assign key_joy1  = keys_s[30:21];
    assign key_joy2  = keys_s[20:11];
    assign key_start = keys_s[10:9];
    assign key_coin  = keys_s[8:7];

    // Directions turn by 90 degrees for vertical screens
    function automatic board_pkg::joy_t map_joy(input board_pkg::joy_t j, input logic rot);
        board_pkg::joy_t r;
        r = rot ? {j[9:4], j[0], j[1], j[3], j[2]} : j;
        return r ^ {$bits(board_pkg::joy_t){INV}};
    endfunction

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            game_joystick1 <= {$bits(board_pkg::joy_t){INV}};   // Idle level
            game_joystick2 <= {$bits(board_pkg::joy_t){INV}};
            game_coin      <= {2{INV}};
            game_start     <= {2{INV}};
            game_service   <= INV;
            pause_tgl      <= 1'b0;
            game_pause     <= 1'b0;
            gfx_en         <= '1;        // All layers shown
            soft_rst       <= 1'b0;
        end else begin
            game_joystick1 <= map_joy(joy1_s | key_joy1, rot_control);
            game_joystick2 <= map_joy(joy2_s | key_joy2, rot_control);
            game_coin      <= {2{INV}} ^ ({joy2_s[COIN_BIT], joy1_s[COIN_BIT]} | key_coin);
            game_start     <= {2{INV}} ^ ({joy2_s[START_BIT], joy1_s[START_BIT]} | key_start);
            game_service   <= keys_s[4] ^ INV;
            pause_tgl      <= pause_tgl ^ pause_rise;
            game_pause     <= (pause_tgl ^ pause_rise) | dip_pause;  // DIP forces pause
            gfx_en         <= gfx_en ^ gfx_rise;
            soft_rst       <= reset_rise;
        end
    end

    // Every layer comes back on after a board reset
    a_gfx_after_rst: assert property (@(posedge clk_sys) game_rst |=> gfx_en == '1)
        else $error("gfx_en not restored after game_rst");

endmodule

// ==== verilog/reset_gen.sv ====
/* Core reset generator
   Any trigger restarts a BOARD_RST_LEN cycle stretch of core_rst */
`timescale 1ns/1ps
`include "board_macros.svh"

module reset_gen (
    input  logic clk_sys,
    input  logic game_rst,
    input  logic rst_req,
    input  logic soft_rst,
    input  logic dip_flip,
    output logic core_rst
);

    localparam int CW = $clog2(`BOARD_RST_LEN);

    board_pkg::rst_state_t state;
    logic [CW-1:0]         cnt;
    logic                  last_flip;
    logic                  trigger;

    // Screen flip changes need a clean restart of the core
    always_ff @(posedge clk_sys) begin
        last_flip <= dip_flip;
    end

    assign trigger = game_rst | rst_req | soft_rst | (dip_flip != last_flip);

    // Any trigger reloads the stretch counter
    always_ff @(posedge clk_sys) begin
        if (trigger) begin
            state <= board_pkg::RST_STRETCH;
            cnt   <= CW'(`BOARD_RST_LEN - 1);
        end else begin
            case (state)
                board_pkg::RST_STRETCH: begin
                    if (cnt == '0) begin
                        state <= board_pkg::RST_IDLE;    // Quiet long enough
                    end else begin
                        cnt <= cnt - CW'(1);
                    end
                end
                default: begin
                    state <= board_pkg::RST_IDLE;
                end
            endcase
        end
    end

    // High for BOARD_RST_LEN cycles after the last trigger
    assign core_rst = state == board_pkg::RST_STRETCH;

    a_rst_follows: assert property (@(posedge clk_sys) game_rst |=> core_rst)
        else $error("core_rst missing after game_rst");

    a_no_early_release: assert property (@(posedge clk_sys) $fell(core_rst) |-> !$past(trigger))
        else $error("core_rst released right after a trigger");

endmodule

// ==== verilog/board_ctrl.sv ====
/* Arcade board control top
   Conditions player inputs, decodes settings and stretches the core reset */
`timescale 1ns/1ps

module board_ctrl #(
    parameter int THREE_BUTTONS     = 0,
    parameter int INPUTS_ACTIVE_LOW = 1
) (
    input  logic                clk_sys,
    input  logic                game_rst,
    input  logic                rst_req,
    input  board_pkg::joy_t     board_joystick1,
    input  board_pkg::joy_t     board_joystick2,
    input  board_pkg::key_t     keys,
    input  board_pkg::status_t  status,
    output logic                core_rst,
    output board_pkg::joy_t     game_joystick1,
    output board_pkg::joy_t     game_joystick2,
    output board_pkg::pair_t    game_coin,
    output board_pkg::pair_t    game_start,
    output logic                game_service,
    output logic                game_pause,
    output board_pkg::gfx_t     gfx_en,
    output logic                dip_flip,
    output logic                dip_test,
    output board_pkg::fxlevel_t dip_fxlevel,
    output logic                enable_fm,
    output logic                enable_psg
);

    board_pkg::joy_t joy1_s, joy2_s;
    board_pkg::key_t keys_s;
    board_pkg::gfx_t gfx_rise;
    logic            pause_rise, reset_rise;
    logic            rot_control, dip_pause;
    logic            soft_rst;

    pad_sync #(.THREE_BUTTONS(THREE_BUTTONS)) u_pad_sync (
        .clk_sys         (clk_sys),
        .game_rst        (game_rst),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .keys            (keys),
        .joy1_s          (joy1_s),
        .joy2_s          (joy2_s),
        .keys_s          (keys_s),
        .pause_rise      (pause_rise),
        .reset_rise      (reset_rise),
        .gfx_rise        (gfx_rise)
    );

    dip_decode u_dip_decode (
        .clk_sys     (clk_sys),
        .game_rst    (game_rst),
        .status      (status),
        .rot_control (rot_control),
        .dip_flip    (dip_flip),
        .dip_test    (dip_test),
        .dip_pause   (dip_pause),
        .dip_fxlevel (dip_fxlevel),
        .enable_fm   (enable_fm),
        .enable_psg  (enable_psg)
    );

    input_mapper #(
        .THREE_BUTTONS     (THREE_BUTTONS),
        .INPUTS_ACTIVE_LOW (INPUTS_ACTIVE_LOW)
    ) u_input_mapper (
        .clk_sys        (clk_sys),
        .game_rst       (game_rst),
        .joy1_s         (joy1_s),
        .joy2_s         (joy2_s),
        .keys_s         (keys_s),
        .pause_rise     (pause_rise),
        .reset_rise     (reset_rise),
        .gfx_rise       (gfx_rise),
        .rot_control    (rot_control),
        .dip_pause      (dip_pause),
        .game_joystick1 (game_joystick1),
        .game_joystick2 (game_joystick2),
        .game_coin      (game_coin),
        .game_start     (game_start),
        .game_service   (game_service),
        .game_pause     (game_pause),
        .gfx_en         (gfx_en),
        .soft_rst       (soft_rst)
    );

    reset_gen u_reset_gen (
        .clk_sys  (clk_sys),
        .game_rst (game_rst),
        .rst_req  (rst_req),
        .soft_rst (soft_rst),
        .dip_flip (dip_flip),
        .core_rst (core_rst)
    );

endmodule

// ==== tb/board_ctrl_tb.sv ====
/* Testbench for the board control block
   Random pads, keys and status checked against a cycle model */
`timescale 1ns/1ps
`include "board_macros.svh"

module board_ctrl_tb;

    localparam int CLK_PERIOD_NS = 4;
    localparam int RST_CYCLES    = 5;
    localparam int RUN_CYCLES    = 4000;
    localparam int WATCHDOG_NS   = (RST_CYCLES + RUN_CYCLES) * CLK_PERIOD_NS + 400;
    localparam bit ACTIVE_LOW    = 1'b1;

    logic clk_sys = 1'b0;
    logic game_rst, rst_req, core_rst;
    board_pkg::joy_t     board_joystick1, board_joystick2, game_joystick1, game_joystick2;
    board_pkg::key_t     keys, next_keys;
    board_pkg::status_t  status;
    board_pkg::pair_t    game_coin, game_start;
    board_pkg::gfx_t     gfx_en;
    board_pkg::fxlevel_t dip_fxlevel;
    logic game_service, game_pause, dip_flip, dip_test, enable_fm, enable_psg;

    // Model state updated on each rising edge
    board_pkg::joy_t     s0_joy1, s0_joy2, s1_joy1, s1_joy2, exp_joy1, exp_joy2;
    board_pkg::key_t     s0_keys, s1_keys;
    board_pkg::pair_t    exp_coin, exp_start;
    board_pkg::gfx_t     exp_gfx, m_last_gfx, g_rise;
    board_pkg::fxlevel_t m_fx;
    logic exp_service, exp_pause, m_tgl, m_soft_rst, m_last_kpause, m_last_jpause, m_last_reset;
    logic m_rot, m_dip_pause, m_dip_flip, m_prev_flip, m_dip_test, m_fm, m_psg;
    logic jp, p_rise, r_rise, trig, model_valid = 1'b0, prev_core_rst = 1'b1;
    int   m_quiet = `BOARD_RST_LEN;
    int   release_count = 0;
    integer      seed;
    logic [31:0] rnd;
    logic [2:0]  joy_hold, key_hold;

    board_ctrl #(.THREE_BUTTONS(0), .INPUTS_ACTIVE_LOW(1)) u_board_ctrl (.*);

    always #(CLK_PERIOD_NS / 2) clk_sys = ~clk_sys;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        abort_run($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_joy(input string what, input board_pkg::joy_t got,
                             input board_pkg::joy_t exp);
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic check_pair(input string what, input board_pkg::pair_t got,
                              input board_pkg::pair_t exp);
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic check_gfx(input string what, input board_pkg::gfx_t got,
                             input board_pkg::gfx_t exp);
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic check_fx(input string what, input board_pkg::fxlevel_t got,
                            input board_pkg::fxlevel_t exp);
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    // Pad and key merged before the turn and the polarity
    function automatic board_pkg::joy_t player_joy(input board_pkg::joy_t pad,
                                                   input board_pkg::joy_t key_joy,
                                                   input logic rot);
        board_pkg::joy_t merged;
        board_pkg::joy_t turned;
        merged = pad | key_joy;
        turned = merged;
        if (rot) begin
            turned[3] = merged[0];
            turned[2] = merged[1];
            turned[1] = merged[3];
            turned[0] = merged[2];
        end
        return ACTIVE_LOW ? ~turned : turned;
    endfunction

    // Player 2 in the high bit
    function automatic board_pkg::pair_t pair_level(input logic p2_btn, input logic p1_btn,
                                                    input board_pkg::pair_t key_pair);
        board_pkg::pair_t pressed;
        pressed = {p2_btn, p1_btn} | key_pair;
        return ACTIVE_LOW ? ~pressed : pressed;
    endfunction

    always @(posedge clk_sys) begin
        jp     = s1_joy1[`BOARD_PAUSE_BIT] | s1_joy2[`BOARD_PAUSE_BIT];
        p_rise = (s1_keys[5] & ~m_last_kpause) | (jp & ~m_last_jpause);
        r_rise = s1_keys[6] & ~m_last_reset;
        g_rise = s1_keys[3:0] & ~m_last_gfx;
        trig   = game_rst | rst_req | m_soft_rst | (m_dip_flip != m_prev_flip);
        if (trig) begin
            m_quiet = 0;                          // Stretch restarts
        end else if (m_quiet < `BOARD_RST_LEN) begin
            m_quiet = m_quiet + 1;
        end
        m_prev_flip = m_dip_flip;
        if (game_rst) begin
            exp_joy1    = {$bits(board_pkg::joy_t){ACTIVE_LOW}};
            exp_joy2    = {$bits(board_pkg::joy_t){ACTIVE_LOW}};
            exp_coin    = {2{ACTIVE_LOW}};
            exp_start   = {2{ACTIVE_LOW}};
            exp_service = ACTIVE_LOW;
            m_tgl       = 1'b0;
            exp_pause   = 1'b0;
            exp_gfx     = '1;
            m_soft_rst  = 1'b0;
            m_last_kpause = 1'b1;                 // Key held through reset gives no edge
            m_last_jpause = 1'b1;
            m_last_reset  = 1'b1;
            m_last_gfx    = '1;
            {m_rot, m_dip_flip, m_dip_test, m_dip_pause, m_fx, m_fm, m_psg} = '0;
        end else begin
            exp_joy1    = player_joy(s1_joy1, s1_keys[30:21], m_rot);
            exp_joy2    = player_joy(s1_joy2, s1_keys[20:11], m_rot);
            exp_coin    = pair_level(s1_joy2[`BOARD_COIN_BIT], s1_joy1[`BOARD_COIN_BIT],
                                     s1_keys[8:7]);
            exp_start   = pair_level(s1_joy2[`BOARD_START_BIT], s1_joy1[`BOARD_START_BIT],
                                     s1_keys[10:9]);
            exp_service = ACTIVE_LOW ? ~s1_keys[4] : s1_keys[4];
            m_tgl       = m_tgl ^ p_rise;
            exp_pause   = m_tgl | m_dip_pause;    // Old DIP value, settings update below
            exp_gfx     = exp_gfx ^ g_rise;
            m_soft_rst  = r_rise;
            m_last_kpause = s1_keys[5];
            m_last_jpause = jp;
            m_last_reset  = s1_keys[6];
            m_last_gfx    = s1_keys[3:0];
            m_rot       = status[`BOARD_ST_ROT];
            m_dip_flip  = status[`BOARD_ST_FLIP];
            m_dip_test  = status[`BOARD_ST_TEST];
            m_dip_pause = status[`BOARD_ST_PAUSE];
            m_fx        = status[`BOARD_ST_FX_LO +: 2];
            m_fm        = status[`BOARD_ST_FM];
            m_psg       = status[`BOARD_ST_PSG];
        end
        s1_joy1 = s0_joy1;                        // Two-flop synchroniser
        s1_joy2 = s0_joy2;
        s1_keys = s0_keys;
        s0_joy1 = board_joystick1;
        s0_joy2 = board_joystick2;
        s0_keys = keys;
        model_valid = 1'b1;
    end

    // Outputs are settled half a cycle after the edge
    always @(negedge clk_sys) begin
        if (model_valid) begin
            check_joy("game_joystick1", game_joystick1, exp_joy1);
            check_joy("game_joystick2", game_joystick2, exp_joy2);
            check_pair("game_coin", game_coin, exp_coin);
            check_pair("game_start", game_start, exp_start);
            check_bit("game_service", game_service, exp_service);
            check_bit("game_pause", game_pause, exp_pause);
            check_gfx("gfx_en", gfx_en, exp_gfx);
            check_bit("core_rst", core_rst, m_quiet < `BOARD_RST_LEN);
            check_bit("dip_flip", dip_flip, m_dip_flip);
            check_bit("dip_test", dip_test, m_dip_test);
            check_fx("dip_fxlevel", dip_fxlevel, m_fx);
            check_bit("enable_fm", enable_fm, m_fm);
            check_bit("enable_psg", enable_psg, m_psg);
            if (prev_core_rst && !core_rst) release_count++;
            prev_core_rst = core_rst;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Timeout: the simulation ran past its time limit");
    end

    initial begin
        seed            = 32'h82e3;
        game_rst        = 1'b1;
        rst_req         = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        keys            = '0;
        status          = '0;
        joy_hold        = '0;
        key_hold        = '0;
        repeat (RST_CYCLES) @(posedge clk_sys);
        game_rst <= 1'b0;
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            @(posedge clk_sys);
            rnd = $random(seed);
            rst_req <= rnd[7:0] == 8'd0;          // Rare one-cycle request
            if (rnd[15:9] == 7'd0) status <= $random(seed);
            if (joy_hold == 3'd0) begin
                rnd = $random(seed);
                board_joystick1 <= rnd[9:0];
                board_joystick2 <= rnd[19:10];
                joy_hold = rnd[22:20];            // Held 1 to 8 cycles
            end else begin
                joy_hold = joy_hold - 3'd1;
            end
            if (key_hold == 3'd0) begin
                rnd = $random(seed);
                next_keys = rnd[30:0];
                rnd = $random(seed);
                next_keys[6] = rnd[4:0] == 5'd0;  // Soft reset key pressed seldom
                key_hold = rnd[7:5];
                keys <= next_keys;
            end else begin
                key_hold = key_hold - 3'd1;
            end
        end
        @(negedge clk_sys);
        if (release_count == 0) begin
            abort_run("core_rst was never released during the run");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/board_pkg.sv
verilog/pad_sync.sv
verilog/dip_decode.sv
verilog/input_mapper.sv
verilog/reset_gen.sv
verilog/board_ctrl.sv
tb/board_ctrl_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := board_ctrl_tb
FILELIST   := files.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert --Mdir $(OBJ_DIR)
PASS_MSG   := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
